// ==== hw/fp_pkg.sv ====
// Single-precision float format, field widths, struct and special values
package fp_pkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int EXP_W  = 8;                  // Biased exponent bits
    localparam int MANT_W = 23;                 // Stored mantissa bits, hidden one not stored

    // Exponent encodings
    localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;   // Exponent of 1.0
    localparam logic [EXP_W-1:0] EXP_MAX  = '1;       // Reserved for infinity and NaN

    // --------------------
    // Float word
    // --------------------
    // Sign on top, then exponent, then mantissa, 32 bits in all
    typedef struct packed {
        logic              sign;                // 1 means negative
        logic [EXP_W-1:0]  exp;                 // Biased exponent
        logic [MANT_W-1:0] mant;                // Fraction below the hidden one
    } float_t;

    // --------------------
    // Special values
    // --------------------
    localparam float_t FLOAT_ZERO = '{        // Positive zero
        sign: 1'b0,
        exp:  '0,
        mant: '0
    };

    localparam float_t FLOAT_INF = '{         // Positive infinity
        sign: 1'b0,
        exp:  EXP_MAX,
        mant: '0
    };

    // Quiet NaN, top mantissa bit set
    localparam float_t FLOAT_QNAN = '{
        sign: 1'b0,
        exp:  EXP_MAX,
        mant: {1'b1, {(MANT_W-1){1'b0}}}
    };

endpackage

// ==== hw/adc_pkg.sv ====
// ADC sample widths, fixed-point sample types and pipeline latencies
package adc_pkg;

    // --------------------
    // Sample widths
    // --------------------
    localparam int X_W   = 12;                  // Width of x channel
    localparam int YZ_W  = 10;                  // Width of y and z channels
    localparam int OUT_W = 12;                  // Width of saturated result

    // --------------------
    // Fixed-point types
    // --------------------
    // All samples are unsigned integers straight from the ADC
    typedef logic [X_W-1:0]   x_fixed_t;        // x operand
    typedef logic [YZ_W-1:0]  yz_fixed_t;       // y or z operand
    typedef logic [OUT_W-1:0] out_fixed_t;      // x*y/z, clipped to OUT_W bits

    // --------------------
    // Latencies in clocks
    // --------------------
    localparam int DIV_LAT = 2;                 // Divider stages, also x alignment depth

    // Converter in, divider, multiplier, converter out
    localparam int PIPE_LAT = 1 + DIV_LAT + 1 + 1;

endpackage

// ==== hw/fixed_to_float.sv ====
// Unsigned fixed-point to single-precision converter with registered output
`timescale 1ns/1ps

module fixed_to_float #(
    parameter type fixed_t = logic [11:0]       // Sample type, width taken from it
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  fixed_t         fixed_i,             // Unsigned integer sample
    output fp_pkg::float_t float_o              // Same value as a float
);

    localparam int FIX_W = $bits(fixed_t);
    localparam int IDX_W = $clog2(FIX_W);       // Bits to index the leading one
    localparam int EW    = fp_pkg::EXP_W;
    localparam int MW    = fp_pkg::MANT_W;

    logic [IDX_W-1:0] lead_idx;                 // Position of highest set bit
    fixed_t           norm;                     // Sample with leading one moved to the top
    fp_pkg::float_t   conv;

    // --------------------
    // Leading one and packing
    // --------------------
    always_comb begin
        lead_idx = '0;
        // Scan upward, last hit is the highest one
        for (int i = 0; i < FIX_W; i++) begin
            if (fixed_i[i]) begin
                lead_idx = IDX_W'(i);
            end
        end

        norm = fixed_i << (IDX_W'(FIX_W - 1) - lead_idx);

        if (fixed_i == '0) begin
            conv = fp_pkg::FLOAT_ZERO;          // No leading one at all
        end else begin
            conv.sign = 1'b0;                   // Samples are unsigned
            conv.exp  = fp_pkg::EXP_BIAS + {{(EW-IDX_W){1'b0}}, lead_idx};
            // Drop the hidden one, left align what is below it
            conv.mant = {norm[FIX_W-2:0], {(MW-FIX_W+1){1'b0}}};
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            float_o <= '0;
        end else begin
            float_o <= conv;
        end
    end

endmodule

// ==== hw/fp_div.sv ====
// Two-stage single-precision divider with zero and divide-by-zero handling
`timescale 1ns/1ps

module fp_div (
    input  logic           clk_i,
    input  logic           rst_i,
    input  fp_pkg::float_t dividend_i,
    input  fp_pkg::float_t divisor_i,
    output fp_pkg::float_t quotient_o
);

    localparam int EW = fp_pkg::EXP_W;
    localparam int MW = fp_pkg::MANT_W;
    localparam int SW = MW + 1;                 // Significand incl. hidden one
    localparam int QW = SW + 1;                 // Quotient kept, ratio in (0.5, 2)

    localparam logic signed [EW+1:0] EXP_ONE = {{(EW+1){1'b0}}, 1'b1};

    // Everything stage two needs, one register
    typedef struct packed {
        logic                 a_zero;           // Dividend is zero
        logic                 b_zero;           // Divisor is zero
        logic                 sign;
        logic signed [EW+1:0] exp_diff;         // Biased, two guard bits
        logic [QW-1:0]        quot;             // Significand ratio times 2^24
    } div_stage_t;

    // --------------------
    // Stage one, divide
    // --------------------
    logic            a_zero;
    logic            b_zero;
    logic [SW-1:0]   a_sig;
    logic [SW-1:0]   b_sig;
    logic [2*SW-1:0] quot_full;
    div_stage_t      stage_d;
    div_stage_t      stage_q;

    assign a_zero = (dividend_i.exp == '0) && (dividend_i.mant == '0);
    assign b_zero = (divisor_i.exp == '0) && (divisor_i.mant == '0);
    assign a_sig  = {|dividend_i.exp, dividend_i.mant};   // Hidden one unless subnormal
    assign b_sig  = {|divisor_i.exp, divisor_i.mant};

    always_comb begin
        quot_full = '0;
        if (!b_zero) begin                      // Keep the divider off a zero divisor
            // Scale dividend first so the quotient keeps full precision
            quot_full = {a_sig, {SW{1'b0}}} / {{SW{1'b0}}, b_sig};
        end

        stage_d.a_zero   = a_zero;
        stage_d.b_zero   = b_zero;
        stage_d.sign     = dividend_i.sign ^ divisor_i.sign;
        stage_d.exp_diff = $signed({2'b00, dividend_i.exp}) - $signed({2'b00, divisor_i.exp})
                           + $signed({2'b00, fp_pkg::EXP_BIAS});
        stage_d.quot     = quot_full[QW-1:0];   // Upper bits are zero for normal operands
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            stage_q <= '0;
        end else begin
            stage_q <= stage_d;                 // Class travels with the quotient
        end
    end

    // --------------------
    // Stage two, normalize
    // --------------------
    logic signed [EW+1:0] res_exp;
    logic [MW-1:0]        res_mant;
    fp_pkg::float_t       result;

    always_comb begin
        if (stage_q.quot[QW-1]) begin           // Ratio in [1, 2)
            res_mant = stage_q.quot[QW-2:1];
            res_exp  = stage_q.exp_diff;
        end else begin                          // Ratio below 1, one left shift
            res_mant = stage_q.quot[QW-3:0];
            res_exp  = stage_q.exp_diff - EXP_ONE;
        end

        if (stage_q.a_zero && stage_q.b_zero) begin
            result = fp_pkg::FLOAT_QNAN;        // 0/0
        end else if (stage_q.a_zero) begin
            result = fp_pkg::FLOAT_ZERO;
        end else if (stage_q.b_zero || (res_exp >= $signed({2'b00, fp_pkg::EXP_MAX}))) begin
            result = fp_pkg::FLOAT_INF;         // x/0 or exponent overflow
        end else begin
            result.sign = stage_q.sign;
            result.exp  = res_exp[EW-1:0];
            result.mant = res_mant;             // Truncated
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            quotient_o <= '0;
        end else begin
            quotient_o <= result;
        end
    end

endmodule

// ==== hw/fp_mul.sv ====
// One-stage single-precision multiplier with zero, infinity, NaN and overflow handling
`timescale 1ns/1ps

module fp_mul (
    input  logic           clk_i,
    input  logic           rst_i,
    input  fp_pkg::float_t a_i,
    input  fp_pkg::float_t b_i,
    output fp_pkg::float_t product_o
);

    localparam int EW = fp_pkg::EXP_W;
    localparam int MW = fp_pkg::MANT_W;
    localparam int SW = MW + 1;                 // Significand incl. hidden one
    localparam int PW = 2 * SW;                 // Full product width

    localparam logic signed [EW+1:0] EXP_ONE = {{(EW+1){1'b0}}, 1'b1};

    // --------------------
    // Operand classes
    // --------------------
    logic a_zero;
    logic b_zero;
    logic any_nan;
    logic any_inf;

    assign a_zero  = (a_i.exp == '0) && (a_i.mant == '0);
    assign b_zero  = (b_i.exp == '0) && (b_i.mant == '0);
    assign any_nan = ((a_i.exp == fp_pkg::EXP_MAX) && (a_i.mant != '0))
                  || ((b_i.exp == fp_pkg::EXP_MAX) && (b_i.mant != '0));
    assign any_inf = ((a_i.exp == fp_pkg::EXP_MAX) && (a_i.mant == '0))
                  || ((b_i.exp == fp_pkg::EXP_MAX) && (b_i.mant == '0));

    // --------------------
    // Significand product
    // --------------------
    logic [PW-1:0]        sig_prod;
    logic signed [EW+1:0] exp_sum;              // Biased sum, two guard bits
    logic signed [EW+1:0] res_exp;
    logic [MW-1:0]        res_mant;
    fp_pkg::float_t       result;

    always_comb begin
        sig_prod = {{SW{1'b0}}, |a_i.exp, a_i.mant} * {{SW{1'b0}}, |b_i.exp, b_i.mant};
        exp_sum  = $signed({2'b00, a_i.exp}) + $signed({2'b00, b_i.exp})
                   - $signed({2'b00, fp_pkg::EXP_BIAS});

        // Product of two [1, 2) values lies in [1, 4)
        if (sig_prod[PW-1]) begin
            res_mant = sig_prod[PW-2:PW-1-MW];
            res_exp  = exp_sum + EXP_ONE;
        end else begin
            res_mant = sig_prod[PW-3:PW-2-MW];
            res_exp  = exp_sum;
        end

        if (a_zero || b_zero) begin
            result = fp_pkg::FLOAT_ZERO;        // Zero wins over everything
        end else if (any_nan) begin
            result = fp_pkg::FLOAT_QNAN;
        end else if (any_inf || (res_exp >= $signed({2'b00, fp_pkg::EXP_MAX}))) begin
            result = fp_pkg::FLOAT_INF;         // Infinite operand or overflow
        end else begin
            result.sign = a_i.sign ^ b_i.sign;
            result.exp  = res_exp[EW-1:0];
            result.mant = res_mant;             // Truncated
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            product_o <= '0;
        end else begin
            product_o <= result;
        end
    end

endmodule

// ==== hw/float_to_fixed.sv ====
// Single-precision to saturated unsigned fixed-point converter, registered output
`timescale 1ns/1ps

module float_to_fixed #(
    parameter int OUT_W = 12                    // Integer bits of the result
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  fp_pkg::float_t   float_i,
    output logic [OUT_W-1:0] fixed_o
);

    localparam int EW   = fp_pkg::EXP_W;
    localparam int MW   = fp_pkg::MANT_W;
    localparam int SW   = MW + 1;               // Significand incl. hidden one
    localparam int SH_W = $clog2(SW);           // Right shift amount bits

    logic [SW-1:0]    sig;
    logic [EW-1:0]    unb_exp;                  // Unbiased, valid when exp >= bias
    logic [SW-1:0]    int_part;
    logic [OUT_W-1:0] fixed_d;

    assign sig     = {1'b1, float_i.mant};
    assign unb_exp = float_i.exp - fp_pkg::EXP_BIAS;

    // --------------------
    // Integer extraction
    // --------------------
    always_comb begin
        int_part = '0;
        if (float_i.exp == fp_pkg::EXP_MAX) begin
            // Infinity clips high, NaN maps to zero
            fixed_d = (float_i.mant == '0) ? '1 : '0;
        end else if (float_i.exp < fp_pkg::EXP_BIAS) begin
            fixed_d = '0;                       // Below one, also zero and subnormals
        end else if (unb_exp >= EW'(OUT_W)) begin
            fixed_d = '1;                       // Too large, saturate
        end else begin
            // Keep integer part only, fraction truncated
            int_part = sig >> (SH_W'(MW) - unb_exp[SH_W-1:0]);
            fixed_d  = int_part[OUT_W-1:0];
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            fixed_o <= '0;
        end else begin
            fixed_o <= fixed_d;
        end
    end

endmodule

// ==== hw/adc_mul.sv ====
// ADC multiplier top, computes x*y/z in float and returns a saturated integer
`timescale 1ns/1ps

module adc_mul (
    input  logic                clk_i,
    input  logic                rst_i,
    input  adc_pkg::x_fixed_t   x_i,
    input  adc_pkg::yz_fixed_t  y_i,
    input  adc_pkg::yz_fixed_t  z_i,
    output adc_pkg::out_fixed_t fp_o            // x*y/z, truncated and clipped
);

    localparam int DLY = adc_pkg::DIV_LAT;      // x waits as long as the divider

    fp_pkg::float_t           x_flt;
    fp_pkg::float_t           y_flt;
    fp_pkg::float_t           z_flt;
    fp_pkg::float_t           ratio_flt;        // y/z
    fp_pkg::float_t [DLY-1:0] x_dly_q;          // Alignment shift register
    fp_pkg::float_t           prod_flt;

    // --------------------
    // Ratio path
    // --------------------
    fixed_to_float #(.fixed_t(adc_pkg::yz_fixed_t)) i_y_to_float (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .fixed_i (y_i),
        .float_o (y_flt)
    );

    fixed_to_float #(.fixed_t(adc_pkg::yz_fixed_t)) i_z_to_float (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .fixed_i (z_i),
        .float_o (z_flt)
    );

    fp_div i_fp_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dividend_i (y_flt),
        .divisor_i  (z_flt),
        .quotient_o (ratio_flt)
    );

    // --------------------
    // Operand path
    // --------------------
    fixed_to_float #(.fixed_t(adc_pkg::x_fixed_t)) i_x_to_float (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .fixed_i (x_i),
        .float_o (x_flt)
    );

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            x_dly_q <= '0;
        end else begin
            x_dly_q[0] <= x_flt;
            for (int i = 1; i < DLY; i++) begin
                x_dly_q[i] <= x_dly_q[i-1];     // One stage per divider stage
            end
        end
    end

    // --------------------
    // Combine stage
    // --------------------
    fp_mul i_fp_mul (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .a_i       (x_dly_q[DLY-1]),            // x of the same sample as the ratio
        .b_i       (ratio_flt),
        .product_o (prod_flt)
    );

    float_to_fixed #(.OUT_W(adc_pkg::OUT_W)) i_float_to_fixed (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .float_i (prod_flt),
        .fixed_o (fp_o)
    );

endmodule

// ==== testbench/adc_mul_assert.sv ====
// Concurrent port checks for the ADC multiplier, bound into the top level
`timescale 1ns/1ps

module adc_mul_assert (
    input logic                clk_i,
    input logic                rst_i,
    input adc_pkg::x_fixed_t   x_i,
    input adc_pkg::yz_fixed_t  y_i,
    input adc_pkg::yz_fixed_t  z_i,
    input adc_pkg::out_fixed_t fp_o
);

    localparam int LAT = adc_pkg::PIPE_LAT;     // Input edge to visible result

    int failures;                               // Failed assertions so far

    initial failures = 0;

    // --------------------
    // Reset
    // --------------------
    // All stages clear, so nothing but zero reaches the port
    reset_clears_out: assert property (@(posedge clk_i) rst_i |-> (fp_o == '0))
        else begin
            $error("fp_o is %0d while rst_i is high", fp_o);
            failures++;
        end

    // --------------------
    // Zero and divide by zero
    // --------------------
    zero_operand_out: assert property (@(posedge clk_i) disable iff (rst_i)
        ((x_i == '0) || (y_i == '0)) |-> ##LAT (fp_o == '0))
        else begin
            $error("x or y was zero but fp_o is %0d", fp_o);
            failures++;
        end

    // Infinity from the divider must clip high
    div_zero_saturates: assert property (@(posedge clk_i) disable iff (rst_i)
        ((z_i == '0) && (x_i != '0) && (y_i != '0)) |-> ##LAT (fp_o == '1))
        else begin
            $error("z was zero with x and y set but fp_o is %0d", fp_o);
            failures++;
        end

endmodule

bind adc_mul adc_mul_assert i_adc_mul_assert (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .x_i   (x_i),
    .y_i   (y_i),
    .z_i   (z_i),
    .fp_o  (fp_o)
);

// ==== testbench/tb_adc_mul.sv ====
// Testbench for the ADC multiplier, LFSR stimulus checked against an integer model
`timescale 1ns/1ps

module tb_adc_mul #(
    parameter logic [31:0] SEED = 32'hb5c       // LFSR start state
);

    localparam int LAT       = adc_pkg::PIPE_LAT;
    localparam int EW        = fp_pkg::EXP_W;
    localparam int MW        = fp_pkg::MANT_W;
    localparam int BIAS      = int'(fp_pkg::EXP_BIAS);
    localparam int EMAX      = int'(fp_pkg::EXP_MAX);
    localparam int RESET_CYC = 3;
    localparam int DRIVE_DLY = 2;               // ns after rising edge
    localparam int N_IDLE    = LAT;
    localparam int N_RANDOM  = 400;
    localparam int N_ZERO    = 100;
    localparam int N_DIVZ    = 100;
    localparam int N_LIMIT   = 100;

    // Every test drains LAT cycles, plus one more LAT of slack
    localparam int TOTAL_CYC = RESET_CYC + N_IDLE + N_RANDOM + N_ZERO + N_DIVZ + N_LIMIT
                               + 5 * LAT + LAT;
    localparam int TIMEOUT_NS = TOTAL_CYC * 20 + 500;

    // One sample and its expected result
    typedef struct packed {
        adc_pkg::x_fixed_t   x;
        adc_pkg::yz_fixed_t  y;
        adc_pkg::yz_fixed_t  z;
        adc_pkg::out_fixed_t expect_val;
    } sample_t;

    logic                clk_i;
    logic                rst_i;
    adc_pkg::x_fixed_t   x_i;
    adc_pkg::yz_fixed_t  y_i;
    adc_pkg::yz_fixed_t  z_i;
    adc_pkg::out_fixed_t fp_o;

    sample_t     pending_q[$];                  // Samples in flight, oldest first
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;
    int          tests_run;
    int          assert_fails;                  // From the bound port checks

    adc_mul i_adc_mul (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .x_i   (x_i),
        .y_i   (y_i),
        .z_i   (z_i),
        .fp_o  (fp_o)
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;                  // 20 ns period

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic adc_pkg::x_fixed_t rand_x();
        return adc_pkg::x_fixed_t'(random_bits(adc_pkg::X_W));
    endfunction

    function automatic adc_pkg::yz_fixed_t rand_yz();
        return adc_pkg::yz_fixed_t'(random_bits(adc_pkg::YZ_W));
    endfunction

    function automatic adc_pkg::yz_fixed_t rand_nonzero_yz();
        adc_pkg::yz_fixed_t v;
        do begin
            v = rand_yz();                      // Redraw on zero
        end while (v == '0);
        return v;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic bit float_is_zero(fp_pkg::float_t f);
        return (f.exp == '0) && (f.mant == '0);
    endfunction

    function automatic bit float_is_nan(fp_pkg::float_t f);
        return (int'(f.exp) == EMAX) && (f.mant != '0);
    endfunction

    function automatic bit float_is_inf(fp_pkg::float_t f);
        return (int'(f.exp) == EMAX) && (f.mant == '0);
    endfunction

    function automatic fp_pkg::float_t model_to_float(int unsigned v);
        fp_pkg::float_t  f;
        int              idx;
        longint unsigned aligned;
        f   = fp_pkg::FLOAT_ZERO;
        idx = 0;
        if (v != 0) begin
            while ((v >> (idx + 1)) != 0) idx++;            // Leading one position
            aligned = longint'(v) << (MW - idx);            // Leading one on bit MW
            f.exp   = EW'(BIAS + idx);
            f.mant  = aligned[MW-1:0];
        end
        return f;
    endfunction

    function automatic fp_pkg::float_t model_div(fp_pkg::float_t a, fp_pkg::float_t b);
        fp_pkg::float_t  q;
        longint unsigned sig_a;
        longint unsigned sig_b;
        longint unsigned ratio;
        int              e;
        q = fp_pkg::FLOAT_ZERO;
        if (float_is_zero(a) && float_is_zero(b)) begin
            q = fp_pkg::FLOAT_QNAN;
        end else if (float_is_zero(a)) begin
            q = fp_pkg::FLOAT_ZERO;
        end else if (float_is_zero(b)) begin
            q = fp_pkg::FLOAT_INF;
        end else begin
            sig_a = (64'd1 << MW) | a.mant;
            sig_b = (64'd1 << MW) | b.mant;
            ratio = (sig_a << (MW + 1)) / sig_b;            // Scaled before divide
            e     = int'(a.exp) - int'(b.exp) + BIAS;
            if (ratio >= (64'd1 << (MW + 1))) begin
                ratio = ratio >> 1;                         // Ratio of one or more
            end else begin
                e = e - 1;
            end
            if (e >= EMAX) begin
                q = fp_pkg::FLOAT_INF;
            end else begin
                q.sign = a.sign ^ b.sign;
                q.exp  = EW'(e);
                q.mant = ratio[MW-1:0];
            end
        end
        return q;
    endfunction

    function automatic fp_pkg::float_t model_mul(fp_pkg::float_t a, fp_pkg::float_t b);
        fp_pkg::float_t  p;
        longint unsigned prod;
        int              e;
        p = fp_pkg::FLOAT_ZERO;
        if (float_is_zero(a) || float_is_zero(b)) begin
            p = fp_pkg::FLOAT_ZERO;                         // Zero first
        end else if (float_is_nan(a) || float_is_nan(b)) begin
            p = fp_pkg::FLOAT_QNAN;
        end else if (float_is_inf(a) || float_is_inf(b)) begin
            p = fp_pkg::FLOAT_INF;
        end else begin
            prod = ((64'd1 << MW) | a.mant) * ((64'd1 << MW) | b.mant);
            e    = int'(a.exp) + int'(b.exp) - BIAS;
            if (prod >= (64'd1 << (2 * MW + 1))) begin
                prod = prod >> (MW + 1);
                e    = e + 1;
            end else begin
                prod = prod >> MW;
            end
            if (e >= EMAX) begin
                p = fp_pkg::FLOAT_INF;
            end else begin
                p.sign = a.sign ^ b.sign;
                p.exp  = EW'(e);
                p.mant = prod[MW-1:0];
            end
        end
        return p;
    endfunction

    function automatic adc_pkg::out_fixed_t model_to_fixed(fp_pkg::float_t f);
        int              unb;
        longint unsigned sig;
        if (int'(f.exp) == EMAX) begin
            return (f.mant == '0) ? '1 : '0;                // Infinity clips, NaN is zero
        end
        if (int'(f.exp) < BIAS) begin
            return '0;
        end
        unb = int'(f.exp) - BIAS;
        if (unb >= adc_pkg::OUT_W) begin
            return '1;
        end
        sig = (64'd1 << MW) | f.mant;
        return adc_pkg::out_fixed_t'(sig >> (MW - unb));
    endfunction

    function automatic adc_pkg::out_fixed_t model_result(adc_pkg::x_fixed_t x,
                                                         adc_pkg::yz_fixed_t y,
                                                         adc_pkg::yz_fixed_t z);
        return model_to_fixed(model_mul(model_to_float(x),
                                        model_div(model_to_float(y), model_to_float(z))));
    endfunction

    // --------------------
    // Drive and check
    // --------------------
    task automatic check_output();
        sample_t s;
        s = pending_q.pop_front();
        checks++;
        test_checks++;
        assert (fp_o === s.expect_val) else begin
            $display("Fail at %0t: x=%0d y=%0d z=%0d gave fp_o=%0d, expected %0d",
                     $time, s.x, s.y, s.z, fp_o, s.expect_val);
            errors++;
            test_errors++;
        end
    endtask

    // Check the oldest result, then launch a new sample
    task automatic apply_sample(input adc_pkg::x_fixed_t x, input adc_pkg::yz_fixed_t y,
                                input adc_pkg::yz_fixed_t z);
        sample_t s;
        @(posedge clk_i);
        #DRIVE_DLY;
        if (pending_q.size() == LAT) check_output();
        x_i = x;
        y_i = y;
        z_i = z;
        s.x          = x;
        s.y          = y;
        s.z          = z;
        s.expect_val = model_result(x, y, z);
        pending_q.push_back(s);
    endtask

    task automatic drain_pipeline();
        while (pending_q.size() > 0) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            check_output();                     // Inputs held while the last results come out
        end
    endtask

    task automatic end_test(input string name);
        drain_pipeline();
        tests_run++;
        $display("Test %-13s done: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic run_reset_idle();
        repeat (RESET_CYC) begin
            @(posedge clk_i);
            #DRIVE_DLY;
            pending_q.push_back('0);
            check_output();                     // Held in reset
        end
        rst_i = 1'b0;
        repeat (LAT) pending_q.push_back('0);   // Cleared stages still in front
        repeat (N_IDLE) apply_sample(rand_x(), rand_yz(), rand_nonzero_yz());
        end_test("reset_idle");
    endtask

    task automatic run_random_stream();
        repeat (N_RANDOM) apply_sample(rand_x(), rand_yz(), rand_nonzero_yz());
        end_test("random_stream");
    endtask

    task automatic run_zero_xy();
        adc_pkg::x_fixed_t  x;
        adc_pkg::yz_fixed_t y;
        adc_pkg::yz_fixed_t z;
        repeat (N_ZERO) begin
            x = rand_x();
            y = rand_yz();
            z = rand_yz();                      // z zero allowed here
            if (random_bits(1) != 0) x = '0;
            else y = '0;
            apply_sample(x, y, z);
        end
        end_test("zero_xy");
    endtask

    task automatic run_div_by_zero();
        adc_pkg::x_fixed_t  x;
        adc_pkg::yz_fixed_t y;
        repeat (N_DIVZ) begin
            x = rand_x() | adc_pkg::x_fixed_t'(1);
            y = rand_yz() | adc_pkg::yz_fixed_t'(1);
            if (random_bits(1) != 0) apply_sample(x, y, '0);   // Infinity path
            else apply_sample(x, '0, '0);                       // 0/0 path
        end
        end_test("div_by_zero");
    endtask

    task automatic run_range_limits();
        adc_pkg::x_fixed_t  x;
        adc_pkg::yz_fixed_t y;
        adc_pkg::yz_fixed_t z;
        repeat (N_LIMIT) begin
            if (random_bits(1) != 0) begin
                x = rand_x() | adc_pkg::x_fixed_t'(12'h800);   // Large, saturates
                y = rand_yz() | adc_pkg::yz_fixed_t'(10'h200);
                z = adc_pkg::yz_fixed_t'(1);
            end else begin
                z = rand_nonzero_yz();
                y = rand_yz() % z;              // Ratio below one
                x = adc_pkg::x_fixed_t'(1);
            end
            apply_sample(x, y, z);
        end
        end_test("range_limits");
    endtask

    // --------------------
    // Main sequence and watchdog
    // --------------------
    initial begin
        x_i          = '0;
        y_i          = '0;
        z_i          = '0;
        rst_i        = 1'b1;
        lfsr_state   = SEED;
        errors       = 0;
        checks       = 0;
        test_errors  = 0;
        test_checks  = 0;
        tests_run    = 0;
        assert_fails = 0;

        run_reset_idle();
        run_random_stream();
        run_zero_xy();
        run_div_by_zero();
        run_range_limits();

        assert_fails = i_adc_mul.i_adc_mul_assert.failures;
        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not complete within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== adc_mul.f ====
hw/fp_pkg.sv
hw/adc_pkg.sv
hw/fixed_to_float.sv
hw/fp_div.sv
hw/fp_mul.sv
hw/float_to_fixed.sv
hw/adc_mul.sv
testbench/adc_mul_assert.sv
testbench/tb_adc_mul.sv

// ==== Makefile ====
# Verilator build and run of the ADC multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_mul
SEED      ?= 2908
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= adc_mul.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := Finished with no errors

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
	    -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
